//--- csr_ext_pmp.sv
`timescale 1ns/1ps
`default_nettype none
`include "priv_consts.svh"

module csr_ext_pmp import priv_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  csr_addr_t rd_addr,
  input  logic      wr_en,
  input  csr_addr_t wr_addr,
  input  csr_data_t wr_data,
  output csr_data_t ext_rdata,
  output logic      ext_ack
);

  localparam csr_addr_t PMP_BASE = `PMPCFG0_ADDR;
  localparam csr_data_t CFG_MASK = 32'h9F9F9F9F; // Bits 6:5 of each byte reserved

  csr_data_t pmpcfg [4];
  logic      wr_hit;

  assign ext_ack = (rd_addr[11:2] == PMP_BASE[11:2]); // 0x3A0 to 0x3A3
  assign wr_hit  = wr_en && (wr_addr[11:2] == PMP_BASE[11:2]);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 4; i++) pmpcfg[i] <= '0;
    end else if (wr_hit) begin
      pmpcfg[wr_addr[1:0]] <= wr_data & CFG_MASK;
    end
  end

  assign ext_rdata = ext_ack ? pmpcfg[rd_addr[1:0]] : '0;

endmodule

`default_nettype wire

//--- csr_machine_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "priv_consts.svh"

module csr_machine_regs import priv_pkg::*; #(
  parameter int HARTID = 0
) (
  input  logic        CLK,
  input  logic        nRST,
  input  csr_addr_t   rd_addr,
  input  logic        wr_en,
  input  csr_addr_t   wr_addr,
  input  csr_data_t   wr_data,
  input  logic        trap_valid,
  input  csr_data_t   trap_cause,
  input  csr_data_t   trap_epc,
  input  csr_data_t   trap_tval,
  input  priv_level_t trap_priv,
  input  logic        mret,
  input  logic        inst_ret,
  output csr_data_t   rd_data,
  output logic        hit,
  output csr_data_t   mtvec_out,
  output csr_data_t   mepc_out,
  output logic        irq_pending
);

  localparam csr_data_t IRQ_MASK = (32'd1 << `IRQ_MS) | (32'd1 << `IRQ_MT) | (32'd1 << `IRQ_ME);

  csr_data_t   mstatus, mstatus_next, mstatus_wr;
  csr_data_t   mie, mie_next;
  csr_data_t   mip, mip_next;
  csr_data_t   mtvec, mtvec_next, mtvec_wr;
  csr_data_t   mscratch, mscratch_next;
  csr_data_t   mepc, mepc_next;
  csr_data_t   mcause, mcause_next;
  csr_data_t   mtval, mtval_next;
  csr_data_t   mcounteren, mcounteren_next;
  csr_data_t   mcountinhibit, mcountinhibit_next;
  long_csr_t   cycles_full, cycles_next;
  long_csr_t   instret_full, instret_next;
  priv_level_t mpp_wr;

  // Legal-value filtering of the write data
  always_comb begin
    mpp_wr = priv_level_t'(wr_data[`MSTATUS_MPP +: 2]);
    if (mpp_wr == S_MODE || mpp_wr == RESERVED_MODE) mpp_wr = U_MODE; // No S-mode here
    mstatus_wr = '0;
    mstatus_wr[`MSTATUS_MIE]      = wr_data[`MSTATUS_MIE];
    mstatus_wr[`MSTATUS_MPIE]     = wr_data[`MSTATUS_MPIE];
    mstatus_wr[`MSTATUS_MPRV]     = wr_data[`MSTATUS_MPRV];
    mstatus_wr[`MSTATUS_TW]       = wr_data[`MSTATUS_TW];
    mstatus_wr[`MSTATUS_MPP +: 2] = mpp_wr;
    mtvec_wr = wr_data;
    if (wr_data[1:0] > 2'b01) mtvec_wr[1:0] = 2'b00; // Fall back to direct
  end

  always_comb begin
    mstatus_next       = mstatus;
    mie_next           = mie;
    mip_next           = mip;
    mtvec_next         = mtvec;
    mscratch_next      = mscratch;
    mepc_next          = mepc;
    mcause_next        = mcause;
    mtval_next         = mtval;
    mcounteren_next    = mcounteren;
    mcountinhibit_next = mcountinhibit;

    if (wr_en) begin
      case (wr_addr)
        `MSTATUS_ADDR:       mstatus_next = mstatus_wr;
        `MIE_ADDR:           mie_next = wr_data & IRQ_MASK;
        `MIP_ADDR:           mip_next = wr_data & IRQ_MASK;
        `MTVEC_ADDR:         mtvec_next = mtvec_wr;
        `MSCRATCH_ADDR:      mscratch_next = wr_data;
        `MEPC_ADDR:          mepc_next = wr_data;
        `MCAUSE_ADDR:        mcause_next = wr_data;
        `MTVAL_ADDR:         mtval_next = wr_data;
        `MCOUNTEREN_ADDR:    mcounteren_next = wr_data;
        `MCOUNTINHIBIT_ADDR: mcountinhibit_next = wr_data;
        default: ; // Counters and ID registers are read only
      endcase
    end

    // Trap entry and mret take priority over a CSR write
    if (trap_valid) begin
      mepc_next   = trap_epc;
      mcause_next = trap_cause;
      mtval_next  = trap_tval;
      mstatus_next = mstatus;
      mstatus_next[`MSTATUS_MPIE]     = mstatus[`MSTATUS_MIE];
      mstatus_next[`MSTATUS_MIE]      = 1'b0;
      mstatus_next[`MSTATUS_MPP +: 2] = trap_priv;
    end else if (mret) begin
      mstatus_next = mstatus;
      mstatus_next[`MSTATUS_MIE]      = mstatus[`MSTATUS_MPIE];
      mstatus_next[`MSTATUS_MPIE]     = 1'b1;
      mstatus_next[`MSTATUS_MPP +: 2] = U_MODE;
    end
  end

  // Bit 0 is cy, bit 2 is ir
  always_comb begin
    cycles_next  = cycles_full;
    instret_next = instret_full;
    if (mcounteren[0] && !mcountinhibit[0]) cycles_next = cycles_full + 64'd1;
    if (mcounteren[2] && !mcountinhibit[2]) instret_next = instret_full + {63'd0, inst_ret};
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus       <= `MSTATUS_RESET;
      mie           <= '0;
      mip           <= '0;
      mtvec         <= '0;
      mscratch      <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mtval         <= '0;
      mcounteren    <= '1; // Counters visible out of reset
      mcountinhibit <= '0;
      cycles_full   <= '0;
      instret_full  <= '0;
    end else begin
      mstatus       <= mstatus_next;
      mie           <= mie_next;
      mip           <= mip_next;
      mtvec         <= mtvec_next;
      mscratch      <= mscratch_next;
      mepc          <= mepc_next;
      mcause        <= mcause_next;
      mtval         <= mtval_next;
      mcounteren    <= mcounteren_next;
      mcountinhibit <= mcountinhibit_next;
      cycles_full   <= cycles_next;
      instret_full  <= instret_next;
    end
  end

  // Read mux
  always_comb begin
    rd_data = '0;
    hit     = 1'b1;
    case (rd_addr)
      `MSTATUS_ADDR:       rd_data = mstatus;
      `MISA_ADDR:          rd_data = `MISA_VALUE;
      `MIE_ADDR:           rd_data = mie;
      `MIP_ADDR:           rd_data = mip;
      `MTVEC_ADDR:         rd_data = mtvec;
      `MSCRATCH_ADDR:      rd_data = mscratch;
      `MEPC_ADDR:          rd_data = mepc;
      `MCAUSE_ADDR:        rd_data = mcause;
      `MTVAL_ADDR:         rd_data = mtval;
      `MCOUNTEREN_ADDR:    rd_data = mcounteren;
      `MCOUNTINHIBIT_ADDR: rd_data = mcountinhibit;
      `MCYCLE_ADDR:        rd_data = cycles_full[31:0];
      `MCYCLEH_ADDR:       rd_data = cycles_full[63:32];
      `MINSTRET_ADDR:      rd_data = instret_full[31:0];
      `MINSTRETH_ADDR:     rd_data = instret_full[63:32];
      `MHARTID_ADDR:       rd_data = csr_data_t'(HARTID);
      `MVENDORID_ADDR:     rd_data = '0; // Non-commercial
      default:             hit = 1'b0;
    endcase
  end

  assign mtvec_out   = mtvec;
  assign mepc_out    = mepc;
  assign irq_pending = mstatus[`MSTATUS_MIE] && |(mie & mip);

endmodule

`default_nettype wire

//--- csr_req_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module csr_req_ctrl import priv_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        req,
  input  csr_addr_t   addr,
  input  csr_op_t     op,
  input  csr_data_t   wdata,
  input  priv_level_t cur_priv,
  input  logic        rsp_valid,
  input  csr_data_t   rsp_rdata,
  input  logic        rsp_err,
  output logic        ack,
  output csr_data_t   rdata,
  output logic        err,
  output logic        issue,
  output csr_addr_t   iss_addr,
  output csr_op_t     iss_op,
  output csr_data_t   iss_wdata,
  output priv_level_t iss_priv
);

  req_state_t state;
  logic       take_req;
  logic       take_rsp;

  assign take_req = (state == IDLE) && req;
  assign take_rsp = (state == BUSY) && rsp_valid;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      issue <= 1'b0;
      ack   <= 1'b0;
    end else begin
      issue <= take_req; // Single pulse per request
      case (state)
        IDLE: if (req) state <= BUSY;
        BUSY: begin
          if (rsp_valid) begin
            ack   <= 1'b1;
            state <= DONE;
          end
        end
        DONE: begin
          // Hold ack until the core lets go of req
          if (!req) begin
            ack   <= 1'b0;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Request and response payload
  always_ff @(posedge CLK) begin
    if (take_req) begin
      iss_addr  <= addr;
      iss_op    <= op;
      iss_wdata <= wdata;
      iss_priv  <= cur_priv;
    end
    if (take_rsp) begin
      rdata <= rsp_rdata;
      err   <= rsp_err;
    end
  end

endmodule

`default_nettype wire

//--- csr_rmw_stage.sv
`timescale 1ns/1ps
`default_nettype none

module csr_rmw_stage import priv_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        issue,
  input  csr_addr_t   iss_addr,
  input  csr_op_t     iss_op,
  input  csr_data_t   iss_wdata,
  input  priv_level_t iss_priv,
  input  csr_data_t   rd_data,
  input  logic        hit,
  input  csr_data_t   ext_rdata,
  input  logic        ext_ack,
  output csr_addr_t   rd_addr,
  output logic        wr_en,
  output csr_addr_t   wr_addr,
  output csr_data_t   wr_data,
  output logic        rsp_valid,
  output csr_data_t   rsp_rdata,
  output logic        rsp_err
);

  csr_data_t old_val;
  csr_data_t new_val;
  logic      wr_class;
  logic      no_priv;
  logic      bad_err;
  logic      wr_pend; // Enable follows the accepted write by one cycle

  assign rd_addr = iss_addr;

  assign old_val = hit     ? rd_data   :
                   ext_ack ? ext_rdata : '0;

  always_comb begin
    case (iss_op)
      CSR_SET:   new_val = old_val | iss_wdata;
      CSR_CLEAR: new_val = old_val & ~iss_wdata;
      default:   new_val = iss_wdata;
    endcase
  end

  assign wr_class = (iss_op != CSR_READ);
  assign no_priv  = iss_addr[9:8] > iss_priv; // Address encodes its lowest privilege
  assign bad_err  = wr_class && (no_priv || !(hit || ext_ack));

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      rsp_valid <= 1'b0;
      wr_pend   <= 1'b0;
      wr_en     <= 1'b0;
    end else begin
      rsp_valid <= issue;
      wr_pend   <= issue && wr_class && !bad_err;
      wr_en     <= wr_pend;
    end
  end

  always_ff @(posedge CLK) begin
    if (issue) begin
      rsp_rdata <= old_val; // Old value goes back to the core
      rsp_err   <= bad_err;
      wr_addr   <= iss_addr;
      wr_data   <= new_val;
    end
  end

endmodule

`default_nettype wire

//--- priv_consts.svh
`ifndef PRIV_CONSTS_SVH
`define PRIV_CONSTS_SVH

// Machine-mode CSR addresses
`define MSTATUS_ADDR       12'h300
`define MISA_ADDR          12'h301
`define MIE_ADDR           12'h304
`define MTVEC_ADDR         12'h305
`define MCOUNTEREN_ADDR    12'h306
`define MCOUNTINHIBIT_ADDR 12'h320
`define MSCRATCH_ADDR      12'h340
`define MEPC_ADDR          12'h341
`define MCAUSE_ADDR        12'h342
`define MTVAL_ADDR         12'h343
`define MIP_ADDR           12'h344
`define PMPCFG0_ADDR       12'h3A0
`define MCYCLE_ADDR        12'hB00
`define MINSTRET_ADDR      12'hB02
`define MCYCLEH_ADDR       12'hB80
`define MINSTRETH_ADDR     12'hB82
`define MVENDORID_ADDR     12'hF11
`define MHARTID_ADDR       12'hF14

// mstatus fields
`define MSTATUS_MIE  3
`define MSTATUS_MPIE 7
`define MSTATUS_MPP  11 // Two bits at 12:11
`define MSTATUS_MPRV 17
`define MSTATUS_TW   21

// Interrupt bits in mie and mip
`define IRQ_MS 3
`define IRQ_MT 7
`define IRQ_ME 11

`define MISA_VALUE    32'h40101100 // RV32 with I, M, U
`define MSTATUS_RESET 32'h00201800 // tw set, mpp = M

`endif

//--- priv_csr_top.sv
`timescale 1ns/1ps
`default_nettype none

module priv_csr_top import priv_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        req,
  input  csr_addr_t   addr,
  input  csr_op_t     op,
  input  csr_data_t   wdata,
  input  priv_level_t cur_priv,
  output logic        ack,
  output csr_data_t   rdata,
  output logic        err,
  input  logic        trap_valid,
  input  csr_data_t   trap_cause,
  input  csr_data_t   trap_epc,
  input  csr_data_t   trap_tval,
  input  logic        mret,
  input  logic        inst_ret,
  output csr_data_t   mtvec_out,
  output csr_data_t   mepc_out,
  output logic        irq_pending
);

  logic        issue;
  csr_addr_t   iss_addr;
  csr_op_t     iss_op;
  csr_data_t   iss_wdata;
  priv_level_t iss_priv;
  csr_addr_t   rd_addr;
  csr_data_t   rd_data;
  logic        hit;
  csr_data_t   ext_rdata;
  logic        ext_ack;
  logic        wr_en;
  csr_addr_t   wr_addr;
  csr_data_t   wr_data;
  logic        rsp_valid;
  csr_data_t   rsp_rdata;
  logic        rsp_err;

  csr_req_ctrl u_req_ctrl (
    .CLK(CLK), .nRST(nRST),
    .req(req), .addr(addr), .op(op), .wdata(wdata), .cur_priv(cur_priv),
    .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata), .rsp_err(rsp_err),
    .ack(ack), .rdata(rdata), .err(err),
    .issue(issue), .iss_addr(iss_addr), .iss_op(iss_op),
    .iss_wdata(iss_wdata), .iss_priv(iss_priv)
  );

  csr_rmw_stage u_rmw (
    .CLK(CLK), .nRST(nRST),
    .issue(issue), .iss_addr(iss_addr), .iss_op(iss_op),
    .iss_wdata(iss_wdata), .iss_priv(iss_priv),
    .rd_data(rd_data), .hit(hit), .ext_rdata(ext_rdata), .ext_ack(ext_ack),
    .rd_addr(rd_addr), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata), .rsp_err(rsp_err)
  );

  // Trap entry records the privilege the core was running at
  csr_machine_regs #(.HARTID(0)) u_mregs (
    .CLK(CLK), .nRST(nRST),
    .rd_addr(rd_addr), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .trap_valid(trap_valid), .trap_cause(trap_cause), .trap_epc(trap_epc),
    .trap_tval(trap_tval), .trap_priv(cur_priv),
    .mret(mret), .inst_ret(inst_ret),
    .rd_data(rd_data), .hit(hit),
    .mtvec_out(mtvec_out), .mepc_out(mepc_out), .irq_pending(irq_pending)
  );

  csr_ext_pmp u_pmp (
    .CLK(CLK), .nRST(nRST),
    .rd_addr(rd_addr), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .ext_rdata(ext_rdata), .ext_ack(ext_ack)
  );

endmodule

`default_nettype wire

//--- priv_pkg.sv
`default_nettype none

package priv_pkg;

  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;
  typedef logic [63:0] long_csr_t; // Full cycle / instret width

  typedef enum logic [1:0] {
    U_MODE        = 2'b00,
    S_MODE        = 2'b01,
    RESERVED_MODE = 2'b10,
    M_MODE        = 2'b11
  } priv_level_t;

  typedef enum logic [1:0] {
    CSR_READ  = 2'b00,
    CSR_WRITE = 2'b01,
    CSR_SET   = 2'b10,
    CSR_CLEAR = 2'b11
  } csr_op_t;

  // Front end handshake states
  typedef enum logic [1:0] {
    IDLE = 2'b00,
    BUSY = 2'b01,
    DONE = 2'b10
  } req_state_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build with Verilator and run; the exit status carries the result
cd "$(dirname "$0")" &&
  verilator --binary --top-module tb_priv_csr -f src.f -o sim_priv_csr &&
  ./obj_dir/sim_priv_csr ||
  { echo "Simulation build or run failed"; exit 1; }

//--- src.f
+incdir+.
priv_pkg.sv
csr_req_ctrl.sv
csr_rmw_stage.sv
csr_machine_regs.sv
csr_ext_pmp.sv
priv_csr_top.sv
tb_priv_csr.sv

//--- tb_priv_checks.svh
  // Stimulus table with one entry per CSR access
  priv_level_t tbl_priv[$];
  csr_op_t     tbl_op[$];
  csr_addr_t   tbl_addr[$];
  csr_data_t   tbl_wdata[$];
  csr_data_t   tbl_rdata[$];
  logic        tbl_err[$];

  task automatic add_row(input priv_level_t p, input csr_op_t o, input csr_addr_t a,
                         input csr_data_t w, input csr_data_t r, input logic e);
    tbl_priv.push_back(p);
    tbl_op.push_back(o);
    tbl_addr.push_back(a);
    tbl_wdata.push_back(w);
    tbl_rdata.push_back(r);
    tbl_err.push_back(e);
  endtask

  task automatic check_data(input string name, input csr_data_t got, input csr_data_t exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "data mismatch on %s", name);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "flag mismatch on %s", name);
    end
  endtask

  task automatic build_table();
    csr_data_t r0;
    csr_data_t r1;
    csr_data_t r2;
    csr_data_t r3;
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    r3 = $random(seed);
    // Reset values and constant registers
    add_row(M_MODE, CSR_READ, `MISA_ADDR, '0, `MISA_VALUE, 1'b0);
    add_row(M_MODE, CSR_READ, `MSTATUS_ADDR, '0, `MSTATUS_RESET, 1'b0);
    add_row(M_MODE, CSR_READ, `MHARTID_ADDR, '0, 32'h0, 1'b0);
    add_row(M_MODE, CSR_READ, `MCOUNTEREN_ADDR, '0, 32'hFFFF_FFFF, 1'b0);
    // rdata of a mscratch read-modify-write is the old value
    add_row(M_MODE, CSR_WRITE, `MSCRATCH_ADDR, r0, 32'h0, 1'b0);
    add_row(M_MODE, CSR_SET, `MSCRATCH_ADDR, r1, r0, 1'b0);
    add_row(M_MODE, CSR_CLEAR, `MSCRATCH_ADDR, r2, r0 | r1, 1'b0);
    add_row(M_MODE, CSR_WRITE, `MSCRATCH_ADDR, r3, (r0 | r1) & ~r2, 1'b0);
    add_row(M_MODE, CSR_READ, `MSCRATCH_ADDR, '0, r3, 1'b0);
    // mpp of S reads back as U while mie stays set
    add_row(M_MODE, CSR_WRITE, `MSTATUS_ADDR, 32'h0000_0808, `MSTATUS_RESET, 1'b0);
    add_row(M_MODE, CSR_READ, `MSTATUS_ADDR, '0, 32'h0000_0008, 1'b0);
    add_row(M_MODE, CSR_WRITE, `MTVEC_ADDR, 32'h8000_0103, 32'h0, 1'b0);
    add_row(M_MODE, CSR_READ, `MTVEC_ADDR, '0, 32'h8000_0100, 1'b0); // Mode 3 falls back to direct
    add_row(M_MODE, CSR_WRITE, `MIE_ADDR, 32'hFFFF_FFFF, 32'h0, 1'b0);
    add_row(M_MODE, CSR_READ, `MIE_ADDR, '0, 32'h0000_0888, 1'b0);
    // Privilege and address errors
    add_row(U_MODE, CSR_WRITE, `MSCRATCH_ADDR, 32'hDEAD_BEEF, r3, 1'b1);
    add_row(M_MODE, CSR_READ, `MSCRATCH_ADDR, '0, r3, 1'b0);
    add_row(M_MODE, CSR_WRITE, 12'h7C0, 32'h1, 32'h0, 1'b1);
    add_row(M_MODE, CSR_READ, 12'h7C0, '0, 32'h0, 1'b0);
    add_row(M_MODE, CSR_WRITE, `MCYCLEH_ADDR, 32'h1, 32'h0, 1'b0); // Hits but the write is dropped
    add_row(M_MODE, CSR_READ, `MCYCLEH_ADDR, '0, 32'h0, 1'b0);
    // Bits 6:5 of each PMP config byte read as zero
    add_row(M_MODE, CSR_WRITE, `PMPCFG0_ADDR + 12'h1, 32'hFFFF_FFFF, 32'h0, 1'b0);
    add_row(M_MODE, CSR_READ, `PMPCFG0_ADDR + 12'h1, '0, 32'hFFFF_FFFF & ~32'h6060_6060, 1'b0);
  endtask

//--- tb_priv_csr.sv
`timescale 1ns/1ps
`default_nettype none
`include "priv_consts.svh"

module tb_priv_csr import priv_pkg::*; ();

  logic        CLK;
  logic        nRST;
  logic        req;
  csr_addr_t   addr;
  csr_op_t     op;
  csr_data_t   wdata;
  priv_level_t cur_priv;
  logic        ack;
  csr_data_t   rdata;
  logic        err;
  logic        trap_valid;
  csr_data_t   trap_cause;
  csr_data_t   trap_epc;
  csr_data_t   trap_tval;
  logic        mret;
  logic        inst_ret;
  csr_data_t   mtvec_out;
  csr_data_t   mepc_out;
  logic        irq_pending;
  int          seed = 32'h6e13;

  priv_csr_top i_dut (
    .CLK(CLK), .nRST(nRST),
    .req(req), .addr(addr), .op(op), .wdata(wdata), .cur_priv(cur_priv),
    .ack(ack), .rdata(rdata), .err(err),
    .trap_valid(trap_valid), .trap_cause(trap_cause), .trap_epc(trap_epc),
    .trap_tval(trap_tval), .mret(mret), .inst_ret(inst_ret),
    .mtvec_out(mtvec_out), .mepc_out(mepc_out), .irq_pending(irq_pending)
  );

`include "tb_priv_checks.svh"

  initial CLK = 1'b0;
  always #2 CLK = ~CLK;

  // One four-phase transaction with the response sampled while ack is high
  task automatic access(input priv_level_t p, input csr_op_t o, input csr_addr_t a,
                        input csr_data_t w, output csr_data_t r, output logic e);
    int waited;
    @(posedge CLK);
    #1;
    cur_priv = p;
    op       = o;
    addr     = a;
    wdata    = w;
    req      = 1'b1;
    waited   = 0;
    while (ack !== 1'b1) begin
      @(posedge CLK);
      #1;
      waited++;
      if (waited > 20) begin
        $display("Timeout: ack never rose for the access to %h", a);
        $display("TESTS FAILED");
        $fatal(1, "handshake timeout");
      end
    end
    r      = rdata;
    e      = err;
    req    = 1'b0;
    waited = 0;
    while (ack !== 1'b0) begin
      @(posedge CLK);
      #1;
      waited++;
      if (waited > 20) begin
        $display("Timeout: ack stayed high after req dropped for %h", a);
        $display("TESTS FAILED");
        $fatal(1, "handshake timeout");
      end
    end
  endtask

  initial begin
    csr_data_t got;
    logic      got_err;
    csr_data_t cnt_a;
    csr_data_t cnt_b;
    nRST       = 1'b0;
    req        = 1'b0;
    addr       = '0;
    op         = CSR_READ;
    wdata      = '0;
    cur_priv   = M_MODE;
    trap_valid = 1'b0;
    trap_cause = '0;
    trap_epc   = '0;
    trap_tval  = '0;
    mret       = 1'b0;
    inst_ret   = 1'b0;
    build_table();
    repeat (5) @(posedge CLK);
    #1;
    nRST = 1'b1;

    for (int i = 0; i < tbl_addr.size(); i++) begin
      access(tbl_priv[i], tbl_op[i], tbl_addr[i], tbl_wdata[i], got, got_err);
      check_data($sformatf("rdata row %0d", i), got, tbl_rdata[i]);
      check_flag($sformatf("err row %0d", i), got_err, tbl_err[i]);
    end
    check_data("mtvec_out", mtvec_out, 32'h8000_0100); // Left by the mtvec rows

    // Trap from M-mode while mstatus.mie is set
    @(posedge CLK);
    #1;
    trap_valid = 1'b1;
    trap_epc   = 32'h0000_1234;
    trap_cause = 32'h0000_0002;
    trap_tval  = 32'hBAD0_0001;
    @(posedge CLK);
    #1;
    trap_valid = 1'b0;
    check_data("mepc_out", mepc_out, 32'h0000_1234);
    access(M_MODE, CSR_READ, `MEPC_ADDR, '0, got, got_err);
    check_data("mepc", got, 32'h0000_1234);
    access(M_MODE, CSR_READ, `MCAUSE_ADDR, '0, got, got_err);
    check_data("mcause", got, 32'h0000_0002);
    access(M_MODE, CSR_READ, `MTVAL_ADDR, '0, got, got_err);
    check_data("mtval", got, 32'hBAD0_0001);
    access(M_MODE, CSR_READ, `MSTATUS_ADDR, '0, got, got_err);
    check_data("mstatus", got, (32'd1 << `MSTATUS_MPIE) | (32'd3 << `MSTATUS_MPP));

    @(posedge CLK);
    #1;
    mret = 1'b1;
    @(posedge CLK);
    #1;
    mret = 1'b0;
    access(M_MODE, CSR_READ, `MSTATUS_ADDR, '0, got, got_err);
    check_data("mstatus", got, (32'd1 << `MSTATUS_MIE) | (32'd1 << `MSTATUS_MPIE));

    check_flag("irq_pending", irq_pending, 1'b0); // mip still clear
    access(M_MODE, CSR_WRITE, `MIP_ADDR, 32'd1 << `IRQ_MT, got, got_err);
    check_flag("irq_pending", irq_pending, 1'b1);
    access(M_MODE, CSR_CLEAR, `MSTATUS_ADDR, 32'd1 << `MSTATUS_MIE, got, got_err);
    check_flag("irq_pending", irq_pending, 1'b0);

    // Five retire pulses and none before them
    @(posedge CLK);
    #1;
    inst_ret = 1'b1;
    repeat (5) @(posedge CLK);
    #1;
    inst_ret = 1'b0;
    access(M_MODE, CSR_READ, `MINSTRET_ADDR, '0, got, got_err);
    check_data("minstret", got, 32'd5);

    access(M_MODE, CSR_READ, `MCYCLE_ADDR, '0, cnt_a, got_err);
    access(M_MODE, CSR_READ, `MCYCLE_ADDR, '0, cnt_b, got_err);
    check_flag("mcycle increasing", cnt_b > cnt_a, 1'b1);
    access(M_MODE, CSR_WRITE, `MCOUNTINHIBIT_ADDR, 32'h1, got, got_err); // Inhibit cy
    access(M_MODE, CSR_READ, `MCYCLE_ADDR, '0, cnt_a, got_err);
    access(M_MODE, CSR_READ, `MCYCLE_ADDR, '0, cnt_b, got_err);
    check_data("mcycle", cnt_b, cnt_a);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
